// ==== hw/bus_cfg_pkg.sv ====
`default_nettype none

package bus_cfg_pkg;

    ////////////////////////////////////////////////////////////////////
    // Data bus geometry
    ////////////////////////////////////////////////////////////////////

    // Width of one data beat in bits
    parameter int DATA_BITS = 512;
    // Bytes per beat as a power of two, 64 bytes gives 6
    parameter int BEAT_LOG_BITS = $clog2(DATA_BITS / 8);

    ////////////////////////////////////////////////////////////////////
    // Request field widths
    ////////////////////////////////////////////////////////////////////

    // Byte count minus one
    parameter int LEN_BITS = 16;
    parameter int VADDR_BITS = 48;
    // Largest burst is 2**BLEN_BITS beats
    parameter int BLEN_BITS = 6;
    // Region identifier
    parameter int ID_BITS = 4;

endpackage

`default_nettype wire

// ==== hw/meta_slice.sv ====
`default_nettype none

module meta_slice #(
    parameter type REQ_T = req_types_pkg::rd_req_t
) (
    input  logic aclk,
    input  logic aresetn,

    // Upstream side
    input  logic s_valid,
    output logic s_ready,
    input  REQ_T s_data,

    // Downstream side
    output logic m_valid,
    input  logic m_ready,
    output REQ_T m_data
);

    // Output entry and skid entry
    logic out_valid, skid_valid;
    logic out_valid_n, skid_valid_n;
    logic in_ready;
    REQ_T out_data, skid_data;

    // Output entry free or leaving this cycle
    logic out_free;
    assign out_free = ~out_valid | m_ready;

    always_comb begin
        out_valid_n = out_valid;
        skid_valid_n = skid_valid;
        if (out_free) begin
            // Skid entry drains first, else take the new request
            out_valid_n = skid_valid | (s_valid & in_ready);
            skid_valid_n = 1'b0;
        end else if (s_valid && in_ready) begin
            // Output stalled, park it
            skid_valid_n = 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (aresetn == 1'b0) begin
            out_valid <= 1'b0;
            skid_valid <= 1'b0;
            in_ready <= 1'b0;
        end else begin
            out_valid <= out_valid_n;
            skid_valid <= skid_valid_n;
            // Registered ready, breaks the path from m_ready
            in_ready <= ~skid_valid_n;
        end
    end

    // Payload path
    always_ff @(posedge aclk) begin
        if (out_free) begin
            out_data <= skid_valid ? skid_data : s_data;
        end else if (s_valid && in_ready) begin
            skid_data <= s_data;
        end
    end

    assign s_ready = in_ready;
    assign m_valid = out_valid;
    assign m_data = out_data;

endmodule

`default_nettype wire

// ==== hw/req_credit_gate.sv ====
`default_nettype none

module req_credit_gate #(
    parameter type REQ_T = req_types_pkg::rd_req_t,
    parameter int CREDITS_INIT = 0
) (
    input  logic aclk,
    input  logic aresetn,

    // Incoming requests
    input  logic s_valid,
    output logic s_ready,
    input  REQ_T s_data,

    // One beat credit per high cycle
    input  logic xfer,

    // Gated requests
    output logic m_valid,
    input  logic m_ready,
    output REQ_T m_data
);

    // Counter holds up to twice the largest burst
    localparam int CNT_BITS = bus_cfg_pkg::BLEN_BITS + 1;

    ////////////////////////////////////////////////////////////////////
    // Credit counter
    ////////////////////////////////////////////////////////////////////

    logic [CNT_BITS-1:0] cnt, cnt_n;
    logic                xfer_q;

    // Beats of the pending request
    logic [bus_cfg_pkg::LEN_BITS-1:0] len_beats;
    logic [CNT_BITS-1:0]              n_beats;

    // Slice side
    logic slice_ready;
    logic take;

    always_comb begin
        // Full beats minus one, from the byte count minus one
        len_beats = s_data.len >> bus_cfg_pkg::BEAT_LOG_BITS;
        n_beats = len_beats[CNT_BITS-1:0] + CNT_BITS'(1);
    end

    // Release only when the counter covers the whole request
    assign take = s_valid & slice_ready & (cnt >= n_beats);
    assign s_ready = slice_ready & (cnt >= n_beats);

    always_comb begin
        // Returned credit is always added
        cnt_n = cnt + {{(CNT_BITS-1){1'b0}}, xfer_q};
        // Accepted request consumes its beats
        if (take) begin
            cnt_n = cnt_n - n_beats;
        end
    end

    always_ff @(posedge aclk) begin
        if (aresetn == 1'b0) begin
            cnt <= CNT_BITS'(CREDITS_INIT);
            xfer_q <= 1'b0;
        end else begin
            cnt <= cnt_n;
            // Credit usable one cycle after the pulse
            xfer_q <= xfer;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Output register slice
    ////////////////////////////////////////////////////////////////////

    meta_slice #(
        .REQ_T(REQ_T)
    ) u_slice (
        .aclk   (aclk),
        .aresetn(aresetn),
        .s_valid(take),
        .s_ready(slice_ready),
        .s_data (s_data),
        .m_valid(m_valid),
        .m_ready(m_ready),
        .m_data (m_data)
    );

endmodule

`default_nettype wire

// ==== hw/req_credit_top.sv ====
`default_nettype none

module req_credit_top #(
    parameter int RD_BUF_BEATS = 32
) (
    input  logic                                aclk,
    input  logic                                aresetn,

    // Write requests
    input  logic                                wr_req_valid,
    output logic                                wr_req_ready,
    input  logic [bus_cfg_pkg::VADDR_BITS-1:0]  wr_req_vaddr,
    input  logic [bus_cfg_pkg::LEN_BITS-1:0]    wr_req_len,
    input  logic [bus_cfg_pkg::ID_BITS-1:0]     wr_req_id,
    input  logic                                wr_req_last,

    // Read requests
    input  logic                                rd_req_valid,
    output logic                                rd_req_ready,
    input  logic [bus_cfg_pkg::VADDR_BITS-1:0]  rd_req_vaddr,
    input  logic [bus_cfg_pkg::LEN_BITS-1:0]    rd_req_len,
    input  logic [bus_cfg_pkg::ID_BITS-1:0]     rd_req_id,

    // Beat credits from the data buffers
    input  logic                                wr_xfer,
    input  logic                                rd_xfer,

    // Merged request stream
    output logic                                m_req_valid,
    input  logic                                m_req_ready,
    output req_types_pkg::req_op_t              m_req_op,
    output logic [bus_cfg_pkg::VADDR_BITS-1:0]  m_req_vaddr,
    output logic [bus_cfg_pkg::LEN_BITS-1:0]    m_req_len,
    output logic [bus_cfg_pkg::ID_BITS-1:0]     m_req_id,
    output logic                                m_req_last
);

    req_types_pkg::wr_req_t wr_req_in, wr_req_g;
    req_types_pkg::rd_req_t rd_req_in, rd_req_g;
    req_types_pkg::req_t    m_req;
    logic wr_g_valid, wr_g_ready;
    logic rd_g_valid, rd_g_ready;

    ////////////////////////////////////////////////////////////////////
    // Field packing
    ////////////////////////////////////////////////////////////////////

    assign wr_req_in.vaddr = wr_req_vaddr;
    assign wr_req_in.len = wr_req_len;
    assign wr_req_in.id = wr_req_id;
    assign wr_req_in.last = wr_req_last;

    assign rd_req_in.vaddr = rd_req_vaddr;
    assign rd_req_in.len = rd_req_len;
    assign rd_req_in.id = rd_req_id;

    // Writes wait for landed beats
    req_credit_gate #(
        .REQ_T       (req_types_pkg::wr_req_t),
        .CREDITS_INIT(0)
    ) u_wr_gate (
        .aclk   (aclk),
        .aresetn(aresetn),
        .s_valid(wr_req_valid),
        .s_ready(wr_req_ready),
        .s_data (wr_req_in),
        .xfer   (wr_xfer),
        .m_valid(wr_g_valid),
        .m_ready(wr_g_ready),
        .m_data (wr_req_g)
    );

    // Reads start with the whole read buffer free
    req_credit_gate #(
        .REQ_T       (req_types_pkg::rd_req_t),
        .CREDITS_INIT(RD_BUF_BEATS)
    ) u_rd_gate (
        .aclk   (aclk),
        .aresetn(aresetn),
        .s_valid(rd_req_valid),
        .s_ready(rd_req_ready),
        .s_data (rd_req_in),
        .xfer   (rd_xfer),
        .m_valid(rd_g_valid),
        .m_ready(rd_g_ready),
        .m_data (rd_req_g)
    );

    req_merge u_merge (
        .aclk    (aclk),
        .aresetn (aresetn),
        .wr_valid(wr_g_valid),
        .wr_ready(wr_g_ready),
        .wr_data (wr_req_g),
        .rd_valid(rd_g_valid),
        .rd_ready(rd_g_ready),
        .rd_data (rd_req_g),
        .m_valid (m_req_valid),
        .m_ready (m_req_ready),
        .m_data  (m_req)
    );

    // Output unpacking
    assign m_req_op = m_req.op;
    assign m_req_vaddr = m_req.vaddr;
    assign m_req_len = m_req.len;
    assign m_req_id = m_req.id;
    assign m_req_last = m_req.last;

endmodule

`default_nettype wire

// ==== hw/req_merge.sv ====
`default_nettype none

module req_merge (
    input  logic aclk,
    input  logic aresetn,

    // Gated writes
    input  logic                     wr_valid,
    output logic                     wr_ready,
    input  req_types_pkg::wr_req_t   wr_data,

    // Gated reads
    input  logic                     rd_valid,
    output logic                     rd_ready,
    input  req_types_pkg::rd_req_t   rd_data,

    // Tagged output
    output logic                     m_valid,
    input  logic                     m_ready,
    output req_types_pkg::req_t      m_data
);

    ////////////////////////////////////////////////////////////////////
    // Arbitration
    ////////////////////////////////////////////////////////////////////

    // Set when the last grant went to writes
    logic last_wr;
    logic out_valid;
    logic load;
    logic grant_wr, grant_rd;
    req_types_pkg::req_t sel_req;
    req_types_pkg::req_t out_data;

    // Output register empty or draining
    assign load = ~out_valid | m_ready;

    // Writes win unless reads are waiting and writes went last
    assign grant_wr = wr_valid & (~rd_valid | ~last_wr);
    assign grant_rd = rd_valid & ~grant_wr;

    assign wr_ready = load & grant_wr;
    assign rd_ready = load & grant_rd;

    // Tag the winner
    always_comb begin
        sel_req.op = req_types_pkg::OP_RD;
        sel_req.vaddr = rd_data.vaddr;
        sel_req.len = rd_data.len;
        sel_req.id = rd_data.id;
        // No last on reads
        sel_req.last = 1'b0;
        if (grant_wr) begin
            sel_req.op = req_types_pkg::OP_WR;
            sel_req.vaddr = wr_data.vaddr;
            sel_req.len = wr_data.len;
            sel_req.id = wr_data.id;
            sel_req.last = wr_data.last;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Output register
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk) begin
        if (aresetn == 1'b0) begin
            out_valid <= 1'b0;
            last_wr <= 1'b0;
        end else if (load) begin
            out_valid <= grant_wr | grant_rd;
            // Pointer moves only on a grant
            if (grant_wr || grant_rd) begin
                last_wr <= grant_wr;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (load) begin
            out_data <= sel_req;
        end
    end

    assign m_valid = out_valid;
    assign m_data = out_data;

endmodule

`default_nettype wire

// ==== hw/req_types_pkg.sv ====
`default_nettype none

package req_types_pkg;

    ////////////////////////////////////////////////////////////////////
    // Source side requests
    ////////////////////////////////////////////////////////////////////

    // Write request, last marks the final chunk of a transfer
    typedef struct packed {
        logic [bus_cfg_pkg::VADDR_BITS-1:0] vaddr;
        logic [bus_cfg_pkg::LEN_BITS-1:0]   len;
        logic [bus_cfg_pkg::ID_BITS-1:0]    id;
        logic                               last;
    } wr_req_t;

    // Read request
    typedef struct packed {
        logic [bus_cfg_pkg::VADDR_BITS-1:0] vaddr;
        logic [bus_cfg_pkg::LEN_BITS-1:0]   len;
        logic [bus_cfg_pkg::ID_BITS-1:0]    id;
    } rd_req_t;

    ////////////////////////////////////////////////////////////////////
    // Merged stream
    ////////////////////////////////////////////////////////////////////

    // Opcode tag on the shared path
    typedef enum logic [0:0] {
        OP_RD = 1'b0,
        OP_WR = 1'b1
    } req_op_t;

    // Tagged request, last always zero for reads
    typedef struct packed {
        req_op_t                            op;
        logic [bus_cfg_pkg::VADDR_BITS-1:0] vaddr;
        logic [bus_cfg_pkg::LEN_BITS-1:0]   len;
        logic [bus_cfg_pkg::ID_BITS-1:0]    id;
        logic                               last;
    } req_t;

endpackage

`default_nettype wire

// ==== req_credit_top.f ====
hw/bus_cfg_pkg.sv
hw/req_types_pkg.sv
hw/meta_slice.sv
hw/req_credit_gate.sv
hw/req_merge.sv
hw/req_credit_top.sv
sim/tb_clk_gen.sv
sim/req_credit_tb.sv

// ==== sim/req_credit_tb.sv ====
`default_nettype none

module req_credit_tb;

    localparam int RD_BUF_BEATS = 32;
    localparam int MAX_BEATS = 16;
    localparam int N_REQ_MAX = 40;
    // Every request may wait for all its beats plus pipeline slack
    localparam int CYCLE_LIMIT = N_REQ_MAX * (MAX_BEATS + 10) * 4;
    localparam int MAX_LEN = (MAX_BEATS << bus_cfg_pkg::BEAT_LOG_BITS) - 1;

    logic aclk;
    logic aresetn;

    // DUT inputs
    logic                               wr_req_valid = 1'b0;
    logic [bus_cfg_pkg::VADDR_BITS-1:0] wr_req_vaddr = '0;
    logic [bus_cfg_pkg::LEN_BITS-1:0]   wr_req_len = '0;
    logic [bus_cfg_pkg::ID_BITS-1:0]    wr_req_id = '0;
    logic                               wr_req_last = 1'b0;
    logic                               rd_req_valid = 1'b0;
    logic [bus_cfg_pkg::VADDR_BITS-1:0] rd_req_vaddr = '0;
    logic [bus_cfg_pkg::LEN_BITS-1:0]   rd_req_len = '0;
    logic [bus_cfg_pkg::ID_BITS-1:0]    rd_req_id = '0;
    logic                               wr_xfer = 1'b0;
    logic                               rd_xfer = 1'b0;
    logic                               m_req_ready = 1'b1;

    // DUT outputs
    logic                               wr_req_ready;
    logic                               rd_req_ready;
    logic                               m_req_valid;
    req_types_pkg::req_op_t             m_req_op;
    logic [bus_cfg_pkg::VADDR_BITS-1:0] m_req_vaddr;
    logic [bus_cfg_pkg::LEN_BITS-1:0]   m_req_len;
    logic [bus_cfg_pkg::ID_BITS-1:0]    m_req_id;
    logic                               m_req_last;

    // Scoreboard, one queue per source
    req_types_pkg::req_t wr_q[$];
    req_types_pkg::req_t rd_q[$];

    // Model credits and pending credit pulses
    int wr_credit = 0;
    int rd_credit = RD_BUF_BEATS;
    int wr_pend = 0;
    int rd_pend = 0;
    // Model copies of the registered pulses
    logic wr_xfer_q = 1'b0;
    logic rd_xfer_q = 1'b0;
    logic auto_rd_return = 1'b0;
    logic bp_on = 1'b0;
    int val_errs = 0;
    int other_errs = 0;
    int cycles = 0;
    string test_name = "reset";

    tb_clk_gen #(
        .PERIOD      (20),
        .RESET_CYCLES(4)
    ) u_clk (
        .aclk   (aclk),
        .aresetn(aresetn)
    );

    req_credit_top #(
        .RD_BUF_BEATS(RD_BUF_BEATS)
    ) dut (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .wr_req_valid(wr_req_valid),
        .wr_req_ready(wr_req_ready),
        .wr_req_vaddr(wr_req_vaddr),
        .wr_req_len  (wr_req_len),
        .wr_req_id   (wr_req_id),
        .wr_req_last (wr_req_last),
        .rd_req_valid(rd_req_valid),
        .rd_req_ready(rd_req_ready),
        .rd_req_vaddr(rd_req_vaddr),
        .rd_req_len  (rd_req_len),
        .rd_req_id   (rd_req_id),
        .wr_xfer     (wr_xfer),
        .rd_xfer     (rd_xfer),
        .m_req_valid (m_req_valid),
        .m_req_ready (m_req_ready),
        .m_req_op    (m_req_op),
        .m_req_vaddr (m_req_vaddr),
        .m_req_len   (m_req_len),
        .m_req_id    (m_req_id),
        .m_req_last  (m_req_last)
    );

    ////////////////////////////////////////////////////////////////////
    // Reference model and checks
    ////////////////////////////////////////////////////////////////////

    // Beats of a request from its byte count minus one
    function automatic int exp_beats(input logic [bus_cfg_pkg::LEN_BITS-1:0] len);
        return (int'(len) >> bus_cfg_pkg::BEAT_LOG_BITS) + 1;
    endfunction

    function automatic logic [bus_cfg_pkg::VADDR_BITS-1:0] rand_vaddr();
        logic [63:0] r;
        r = {$urandom, $urandom};
        return r[bus_cfg_pkg::VADDR_BITS-1:0];
    endfunction

    task automatic check_req(input string name, input req_types_pkg::req_t exp,
                             input req_types_pkg::req_t act);
        if (act !== exp) begin
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
            val_errs++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAILED %s: expected %b, actual %b", name, exp, act);
            val_errs++;
        end
    endtask

    task automatic flag_problem(input string what);
        $display("problem: %s", what);
        other_errs++;
    endtask

    ////////////////////////////////////////////////////////////////////
    // Credit returns
    ////////////////////////////////////////////////////////////////////

    // One pulse per cycle while returns are pending
    always @(posedge aclk) begin
        if (aresetn === 1'b1 && wr_pend > 0) begin
            wr_xfer <= 1'b1;
            wr_pend = wr_pend - 1;
        end else begin
            wr_xfer <= 1'b0;
        end
    end

    always @(posedge aclk) begin
        if (aresetn === 1'b1 && rd_pend > 0) begin
            rd_xfer <= 1'b1;
            rd_pend = rd_pend - 1;
        end else begin
            rd_xfer <= 1'b0;
        end
    end

    // Pulse is registered first and counted one edge later
    always @(posedge aclk) begin
        if (wr_xfer_q === 1'b1) begin
            wr_credit = wr_credit + 1;
        end
        if (rd_xfer_q === 1'b1) begin
            rd_credit = rd_credit + 1;
        end
        wr_xfer_q <= wr_xfer;
        rd_xfer_q <= rd_xfer;
    end

    // Random stalls on the shared path
    always @(posedge aclk) begin
        m_req_ready <= bp_on ? ($urandom_range(0, 3) != 0) : 1'b1;
    end

    // Pending counts move on the falling edge away from the pulse logic
    task automatic return_wr(input int n);
        @(negedge aclk);
        wr_pend = wr_pend + n;
    endtask

    task automatic return_rd(input int n);
        @(negedge aclk);
        rd_pend = rd_pend + n;
    endtask

    ////////////////////////////////////////////////////////////////////
    // Request drivers
    ////////////////////////////////////////////////////////////////////

    // Hold valid and fields until ready is seen
    task automatic put_wr(input logic [bus_cfg_pkg::VADDR_BITS-1:0] vaddr,
                          input logic [bus_cfg_pkg::LEN_BITS-1:0] len,
                          input logic [bus_cfg_pkg::ID_BITS-1:0] id, input logic last);
        @(posedge aclk);
        wr_req_valid <= 1'b1;
        wr_req_vaddr <= vaddr;
        wr_req_len <= len;
        wr_req_id <= id;
        wr_req_last <= last;
        @(negedge aclk);
        while (wr_req_ready !== 1'b1) @(negedge aclk);
        @(posedge aclk);
        wr_req_valid <= 1'b0;
    endtask

    task automatic put_rd(input logic [bus_cfg_pkg::VADDR_BITS-1:0] vaddr,
                          input logic [bus_cfg_pkg::LEN_BITS-1:0] len,
                          input logic [bus_cfg_pkg::ID_BITS-1:0] id);
        @(posedge aclk);
        rd_req_valid <= 1'b1;
        rd_req_vaddr <= vaddr;
        rd_req_len <= len;
        rd_req_id <= id;
        @(negedge aclk);
        while (rd_req_ready !== 1'b1) @(negedge aclk);
        @(posedge aclk);
        rd_req_valid <= 1'b0;
    endtask

    // Gate must stay shut and nothing may come out
    task automatic expect_held(input int n, input logic is_wr);
        repeat (n) begin
            @(negedge aclk);
            if (is_wr) begin
                check_flag({test_name, "/wr_ready_low"}, 1'b0, wr_req_ready);
            end else begin
                check_flag({test_name, "/rd_ready_low"}, 1'b0, rd_req_ready);
            end
            check_flag({test_name, "/no_output"}, 1'b0, m_req_valid);
        end
    endtask

    task automatic wait_drain();
        while (wr_q.size() != 0 || rd_q.size() != 0) @(negedge aclk);
        repeat (4) @(negedge aclk);
    endtask

    // Random writes and reads from two parallel sources
    task automatic mixed_traffic(input int n);
        fork
            begin : wr_side
                logic [bus_cfg_pkg::LEN_BITS-1:0] len;
                for (int i = 0; i < n; i++) begin
                    len = 16'($urandom_range(0, MAX_LEN));
                    // Data beats land first
                    return_wr(exp_beats(len));
                    put_wr(rand_vaddr(), len, 4'($urandom), 1'($urandom));
                end
            end
            begin : rd_side
                logic [bus_cfg_pkg::LEN_BITS-1:0] len;
                for (int i = 0; i < n; i++) begin
                    len = 16'($urandom_range(0, MAX_LEN));
                    put_rd(rand_vaddr(), len, 4'($urandom));
                end
            end
        join
    endtask

    ////////////////////////////////////////////////////////////////////
    // Monitors
    ////////////////////////////////////////////////////////////////////

    // Accepted inputs become expected outputs
    always @(negedge aclk) begin : input_monitor
        req_types_pkg::req_t e;
        int b;
        if (aresetn === 1'b1 && wr_req_valid && wr_req_ready === 1'b1) begin
            b = exp_beats(wr_req_len);
            check_flag({test_name, "/wr_credit_cover"}, 1'b1, wr_credit >= b);
            wr_credit = wr_credit - b;
            e.op = req_types_pkg::OP_WR;
            e.vaddr = wr_req_vaddr;
            e.len = wr_req_len;
            e.id = wr_req_id;
            e.last = wr_req_last;
            wr_q.push_back(e);
        end
        if (aresetn === 1'b1 && rd_req_valid && rd_req_ready === 1'b1) begin
            b = exp_beats(rd_req_len);
            check_flag({test_name, "/rd_credit_cover"}, 1'b1, rd_credit >= b);
            rd_credit = rd_credit - b;
            // Buffer drains the beats later
            if (auto_rd_return) begin
                rd_pend = rd_pend + b;
            end
            e.op = req_types_pkg::OP_RD;
            e.vaddr = rd_req_vaddr;
            e.len = rd_req_len;
            e.id = rd_req_id;
            e.last = 1'b0;
            rd_q.push_back(e);
        end
    end

    // Each output transfer against the head of its queue
    always @(negedge aclk) begin : compare
        req_types_pkg::req_t got;
        if (aresetn === 1'b1 && m_req_valid === 1'b1 && m_req_ready === 1'b1) begin
            got.op = m_req_op;
            got.vaddr = m_req_vaddr;
            got.len = m_req_len;
            got.id = m_req_id;
            got.last = m_req_last;
            if (m_req_op === req_types_pkg::OP_WR) begin
                if (wr_q.size() == 0) begin
                    flag_problem({test_name, ": write came out with none expected"});
                end else begin
                    check_req({test_name, "/wr_out"}, wr_q.pop_front(), got);
                end
            end else if (m_req_op === req_types_pkg::OP_RD) begin
                check_flag({test_name, "/rd_last"}, 1'b0, m_req_last);
                if (rd_q.size() == 0) begin
                    flag_problem({test_name, ": read came out with none expected"});
                end else begin
                    check_req({test_name, "/rd_out"}, rd_q.pop_front(), got);
                end
            end else begin
                flag_problem({test_name, ": output carries an unknown opcode"});
            end
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////

    initial begin : watchdog
        while (cycles < CYCLE_LIMIT) begin
            @(posedge aclk);
            cycles = cycles + 1;
        end
        $display("timeout after %0d cycles during %s", cycles, test_name);
        $display("errors: %0d mismatches, %0d other", val_errs, other_errs);
        $display("sim failed");
        $finish;
    end

    initial begin : main
        void'($urandom(14));

        // Outputs low in reset and one cycle after
        do begin
            @(negedge aclk);
            check_flag("reset/m_req_valid", 1'b0, m_req_valid);
            check_flag("reset/wr_req_ready", 1'b0, wr_req_ready);
            check_flag("reset/rd_req_ready", 1'b0, rd_req_ready);
        end while (aresetn !== 1'b1);

        // Five beat write with credits trickling in
        test_name = "wr_gating";
        fork
            put_wr(rand_vaddr(), 16'd273, 4'h5, 1'b1);
            begin
                expect_held(20, 1'b1);
                return_wr(exp_beats(16'd273) - 1);
                wait (wr_pend == 0);
                expect_held(10, 1'b1);
                return_wr(1);
            end
        join
        wait_drain();

        // Two full bursts use up the read buffer
        test_name = "rd_credits";
        put_rd(rand_vaddr(), 16'(MAX_LEN), 4'h1);
        put_rd(rand_vaddr(), 16'(MAX_LEN), 4'h2);
        wait_drain();
        fork
            put_rd(rand_vaddr(), 16'(MAX_LEN), 4'h3);
            begin
                expect_held(20, 1'b0);
                return_rd(MAX_BEATS);
            end
        join
        wait_drain();
        // Refill and let returns follow the reads
        return_rd(RD_BUF_BEATS);
        wait (rd_pend == 0);
        auto_rd_return = 1'b1;

        test_name = "merge";
        mixed_traffic(8);
        wait_drain();

        test_name = "backpressure";
        bp_on = 1'b1;
        mixed_traffic(8);
        wait_drain();
        // Time for a duplicate to show up
        repeat (20) @(negedge aclk);

        $display("errors: %0d mismatches, %0d other", val_errs, other_errs);
        if (val_errs == 0 && other_errs == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/tb_clk_gen.sv ====
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD = 20,
    parameter int RESET_CYCLES = 4
) (
    output logic aclk,
    output logic aresetn
);

    // Free running clock, first rising edge at half a period
    initial begin
        aclk = 1'b0;
        forever #(PERIOD / 2) aclk = ~aclk;
    end

    // Reset held low, released on a rising edge
    initial begin
        aresetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge aclk);
        aresetn <= 1'b1;
    end

endmodule

`default_nettype wire
